/* hdl/dcachePkg.sv */
package dcachePkg;

  // cache geometry
  localparam int AddrWidth    = 32;
  localparam int WordWidth    = 32;
  localparam int WordsPerLine = 4;
  localparam int NumSets      = 16;
  localparam int OffsetBits   = 4;
  localparam int IndexBits    = 4;
  localparam int TagBits      = AddrWidth - IndexBits - OffsetBits;
  // word select within a 16-byte line
  localparam int WordSel      = 2;

  // core side request, one access at a time
  typedef struct packed {
    logic                   write;
    logic [AddrWidth-1:0]   addr;
    logic [WordWidth-1:0]   wdata;
    logic [WordWidth/8-1:0] strb;
  } cpuReqT;

  // miss is set when the access needed a refill
  typedef struct packed {
    logic [WordWidth-1:0] rdata;
    logic                 miss;
  } cpuRspT;

  typedef logic [WordsPerLine-1:0][WordWidth-1:0] lineT;

  typedef struct packed {
    logic [TagBits-1:0] tag;
  } tagEntryT;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WbAddr,
    WbData,
    WbResp,
    RfAddr,
    RfData,
    Finish
  } ctrlStateT;

endpackage

/* hdl/cacheRam.sv */
`timescale 1ns/1ps

module cacheRam #(
  parameter type payloadT = logic [31:0],
  parameter int  Lanes    = 1
) (
  input  logic                            clk,
  input  logic                            en_i,
  input  logic [Lanes-1:0]                we_i,
  input  logic [dcachePkg::IndexBits-1:0] addr_i,
  input  payloadT                         wdata_i,
  output payloadT                         rdata_o
);

  // payload viewed as equal-width lanes
  typedef logic [Lanes-1:0][$bits(payloadT)/Lanes-1:0] laneArrT;

  laneArrT mem [dcachePkg::NumSets];
  laneArrT wdataLanes;

  assign wdataLanes = wdata_i;

  // read-first, old contents come out on a write cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      for (int l = 0; l < Lanes; l++) begin
        if (we_i[l]) begin
          mem[addr_i][l] <= wdataLanes[l];
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* hdl/dcacheTagStore.sv */
`timescale 1ns/1ps

module dcacheTagStore (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rdEn_i,
  input  logic [dcachePkg::IndexBits-1:0] index_i,
  input  dcachePkg::tagEntryT             tag_i,
  input  logic                            fillEn_i,
  input  logic                            fillWay_i,
  input  logic                            dirtySet_i,
  input  logic                            touch_i,
  input  logic                            touchWay_i,
  output logic [1:0]                      hit_o,
  output logic                            victimWay_o,
  output logic                            victimDirty_o,
  output dcachePkg::tagEntryT             victimTag_o
);

  logic [1:0][dcachePkg::NumSets-1:0] valid;
  logic [1:0][dcachePkg::NumSets-1:0] dirty;
  // lru bit holds the most recently used way
  logic [dcachePkg::NumSets-1:0]      lru;
  dcachePkg::tagEntryT [1:0]          tagQ;

  for (genvar w = 0; w < 2; w++) begin : gWay
    cacheRam #(
      .payloadT(dcachePkg::tagEntryT),
      .Lanes   (1)
    ) uTagRam (
      .clk    (clk),
      .en_i   (rdEn_i | fillEn_i),
      .we_i   (fillEn_i && (fillWay_i == 1'(w))),
      .addr_i (index_i),
      .wdata_i(tag_i),
      .rdata_o(tagQ[w])
    );

    assign hit_o[w] = valid[w][index_i] && (tagQ[w] == tag_i);
  end

  // invalid ways are filled first, way 0 before way 1
  always_comb begin
    if (!valid[0][index_i]) begin
      victimWay_o = 1'b0;
    end else if (!valid[1][index_i]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = ~lru[index_i];
    end
  end

  assign victimDirty_o = dirty[victimWay_o][index_i];
  assign victimTag_o   = tagQ[victimWay_o];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (fillEn_i) begin
        valid[fillWay_i][index_i] <= 1'b1;
        dirty[fillWay_i][index_i] <= 1'b0;
      end
      if (touch_i) begin
        lru[index_i] <= touchWay_i;
      end
      // a store into a fresh line wins over the clean fill
      if (dirtySet_i) begin
        dirty[touchWay_i][index_i] <= 1'b1;
      end
    end
  end

endmodule

/* hdl/dcacheCtrl.sv */
`timescale 1ns/1ps

module dcacheCtrl (
  input  logic                              clk,
  input  logic                              rst_n,
  // core side
  input  logic                              reqValid_i,
  input  dcachePkg::cpuReqT                 req_i,
  output logic                              reqReady_o,
  output logic                              rspValid_o,
  output dcachePkg::cpuRspT                 rsp_o,
  // tag store
  output dcachePkg::tagEntryT               lookupTag_o,
  output logic                              fillEn_o,
  output logic                              fillWay_o,
  output logic                              dirtySet_o,
  output logic                              touch_o,
  output logic                              touchWay_o,
  input  logic [1:0]                        hit_i,
  input  logic                              victimWay_i,
  input  logic                              victimDirty_i,
  input  dcachePkg::tagEntryT               victimTag_i,
  // data ways
  output logic                              ramEn_o,
  output logic [dcachePkg::IndexBits-1:0]   ramIndex_o,
  output logic [1:0][dcachePkg::WordsPerLine-1:0] wayWe_o,
  output dcachePkg::lineT                   wayWdata_o,
  input  dcachePkg::lineT [1:0]             wayRdata_i,
  // AXI4-Lite master
  output logic                              awvalid_o,
  input  logic                              awready_i,
  output logic [dcachePkg::AddrWidth-1:0]   awaddr_o,
  output logic                              wvalid_o,
  input  logic                              wready_i,
  output logic [dcachePkg::WordWidth-1:0]   wdata_o,
  output logic [dcachePkg::WordWidth/8-1:0] wstrb_o,
  input  logic                              bvalid_i,
  output logic                              bready_o,
  output logic                              arvalid_o,
  input  logic                              arready_i,
  output logic [dcachePkg::AddrWidth-1:0]   araddr_o,
  input  logic                              rvalid_i,
  input  logic [dcachePkg::WordWidth-1:0]   rdata_i,
  output logic                              rready_o
);

  dcachePkg::ctrlStateT state, stateNext;
  dcachePkg::cpuReqT    reqQ;
  dcachePkg::lineT      victimLine, lineBuf, baseLine, storeLine;
  logic [dcachePkg::TagBits-1:0]   wbTag, reqTag;
  logic [dcachePkg::IndexBits-1:0] reqIndex;
  logic [dcachePkg::WordSel-1:0]   reqWord, beatCnt;
  logic victimWayQ, wSent, accept, hitAny, hitWay;

  function automatic logic [dcachePkg::WordWidth-1:0] mergeBytes(
    input logic [dcachePkg::WordWidth-1:0]   oldWord,
    input logic [dcachePkg::WordWidth-1:0]   newWord,
    input logic [dcachePkg::WordWidth/8-1:0] strb
  );
    logic [dcachePkg::WordWidth-1:0] res;
    res = oldWord;
    for (int b = 0; b < dcachePkg::WordWidth / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign reqIndex = reqQ.addr[dcachePkg::OffsetBits +: dcachePkg::IndexBits];
  assign reqWord  = reqQ.addr[2 +: dcachePkg::WordSel];
  assign reqTag   = reqQ.addr[dcachePkg::AddrWidth-1 -: dcachePkg::TagBits];
  assign accept   = (state == dcachePkg::Idle) && reqValid_i;
  assign hitAny   = |hit_i;
  assign hitWay   = hit_i[1];

  // RAM reads start on the acceptance edge, so index comes straight from the request
  assign ramIndex_o  = (state == dcachePkg::Idle) ?
                       req_i.addr[dcachePkg::OffsetBits +: dcachePkg::IndexBits] : reqIndex;
  assign ramEn_o     = accept || wayWe_o != '0;
  assign lookupTag_o = '{tag: reqTag};

  // store merge, applied to the hit line or to the refilled line
  always_comb begin
    baseLine  = (state == dcachePkg::Finish) ? lineBuf : wayRdata_i[hitWay];
    storeLine = baseLine;
    if (reqQ.write) begin
      storeLine[reqWord] = mergeBytes(baseLine[reqWord], reqQ.wdata, reqQ.strb);
    end
    wayWe_o = '0;
    if (state == dcachePkg::Lookup && hitAny && reqQ.write) begin
      wayWe_o[hitWay][reqWord] = 1'b1;
    end else if (state == dcachePkg::Finish) begin
      wayWe_o[victimWayQ] = '1;
    end
  end

  assign wayWdata_o  = storeLine;
  assign reqReady_o  = (state == dcachePkg::Idle);
  assign rspValid_o  = (state == dcachePkg::Lookup && hitAny) || state == dcachePkg::Finish;
  assign rsp_o.rdata = storeLine[reqWord];
  assign rsp_o.miss  = (state == dcachePkg::Finish);

  assign touch_o    = rspValid_o;
  assign touchWay_o = (state == dcachePkg::Finish) ? victimWayQ : hitWay;
  assign dirtySet_o = rspValid_o && reqQ.write;
  assign fillEn_o   = (state == dcachePkg::Finish);
  assign fillWay_o  = victimWayQ;

  // one word per transfer, AW and W offered together
  assign awvalid_o = (state == dcachePkg::WbAddr);
  assign wvalid_o  = (state == dcachePkg::WbAddr && !wSent) || state == dcachePkg::WbData;
  assign awaddr_o  = {wbTag, reqIndex, beatCnt, 2'b00};
  assign wdata_o   = victimLine[beatCnt];
  assign wstrb_o   = '1;
  assign bready_o  = (state == dcachePkg::WbResp);
  assign arvalid_o = (state == dcachePkg::RfAddr);
  assign araddr_o  = {reqTag, reqIndex, beatCnt, 2'b00};
  assign rready_o  = (state == dcachePkg::RfData);

  always_comb begin
    stateNext = state;
    case (state)
      dcachePkg::Idle:   if (reqValid_i) stateNext = dcachePkg::Lookup;
      dcachePkg::Lookup: begin
        if (hitAny) begin
          stateNext = dcachePkg::Idle;
        end else begin
          stateNext = victimDirty_i ? dcachePkg::WbAddr : dcachePkg::RfAddr;
        end
      end
      dcachePkg::WbAddr: begin
        if (awready_i) begin
          stateNext = (wready_i || wSent) ? dcachePkg::WbResp : dcachePkg::WbData;
        end
      end
      dcachePkg::WbData: if (wready_i) stateNext = dcachePkg::WbResp;
      dcachePkg::WbResp: begin
        if (bvalid_i) stateNext = (&beatCnt) ? dcachePkg::RfAddr : dcachePkg::WbAddr;
      end
      dcachePkg::RfAddr: if (arready_i) stateNext = dcachePkg::RfData;
      dcachePkg::RfData: begin
        if (rvalid_i) stateNext = (&beatCnt) ? dcachePkg::Finish : dcachePkg::RfAddr;
      end
      default:           stateNext = dcachePkg::Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= dcachePkg::Idle;
      beatCnt    <= '0;
      wSent      <= 1'b0;
      victimWayQ <= 1'b0;
    end else begin
      state <= stateNext;
      if (state == dcachePkg::Lookup) begin
        beatCnt    <= '0;
        victimWayQ <= victimWay_i;
      end else if ((bready_o && bvalid_i) || (rready_o && rvalid_i)) begin
        // wraps to zero after the last write-back beat
        beatCnt <= beatCnt + 1'b1;
      end
      if (state == dcachePkg::WbAddr && awready_i) begin
        wSent <= 1'b0;
      end else if (state == dcachePkg::WbAddr && wvalid_o && wready_i) begin
        wSent <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i;
    end
    if (state == dcachePkg::Lookup && !hitAny) begin
      victimLine <= wayRdata_i[victimWay_i];
      wbTag      <= victimTag_i.tag;
    end
    if (rready_o && rvalid_i) begin
      lineBuf[beatCnt] <= rdata_i;
    end
  end

endmodule

/* hdl/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              reqValid_i,
  input  dcachePkg::cpuReqT                 req_i,
  output logic                              reqReady_o,
  output logic                              rspValid_o,
  output dcachePkg::cpuRspT                 rsp_o,
  output logic                              awvalid_o,
  input  logic                              awready_i,
  output logic [dcachePkg::AddrWidth-1:0]   awaddr_o,
  output logic                              wvalid_o,
  input  logic                              wready_i,
  output logic [dcachePkg::WordWidth-1:0]   wdata_o,
  output logic [dcachePkg::WordWidth/8-1:0] wstrb_o,
  input  logic                              bvalid_i,
  output logic                              bready_o,
  output logic                              arvalid_o,
  input  logic                              arready_i,
  output logic [dcachePkg::AddrWidth-1:0]   araddr_o,
  input  logic                              rvalid_i,
  input  logic [dcachePkg::WordWidth-1:0]   rdata_i,
  output logic                              rready_o
);

  dcachePkg::tagEntryT lookupTag, victimTag;
  logic fillEn, fillWay, dirtySet, touch, touchWay;
  logic victimWay, victimDirty, ramEn;
  logic [1:0] hit;
  logic [dcachePkg::IndexBits-1:0] ramIndex;
  logic [1:0][dcachePkg::WordsPerLine-1:0] wayWe;
  dcachePkg::lineT wayWdata;
  dcachePkg::lineT [1:0] wayRdata;

  dcacheCtrl uCtrl (
    .clk, .rst_n, .reqValid_i, .req_i, .reqReady_o, .rspValid_o, .rsp_o,
    .lookupTag_o(lookupTag), .fillEn_o(fillEn), .fillWay_o(fillWay),
    .dirtySet_o(dirtySet), .touch_o(touch), .touchWay_o(touchWay),
    .hit_i(hit), .victimWay_i(victimWay), .victimDirty_i(victimDirty),
    .victimTag_i(victimTag), .ramEn_o(ramEn), .ramIndex_o(ramIndex),
    .wayWe_o(wayWe), .wayWdata_o(wayWdata), .wayRdata_i(wayRdata),
    .awvalid_o, .awready_i, .awaddr_o, .wvalid_o, .wready_i, .wdata_o, .wstrb_o,
    .bvalid_i, .bready_o, .arvalid_o, .arready_i, .araddr_o, .rvalid_i, .rdata_i,
    .rready_o
  );

  dcacheTagStore uTagStore (
    .clk, .rst_n, .rdEn_i(ramEn), .index_i(ramIndex), .tag_i(lookupTag),
    .fillEn_i(fillEn), .fillWay_i(fillWay), .dirtySet_i(dirtySet),
    .touch_i(touch), .touchWay_i(touchWay), .hit_o(hit),
    .victimWay_o(victimWay), .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  // one line-wide RAM per way, one write lane per word
  for (genvar w = 0; w < 2; w++) begin : gDataWay
    cacheRam #(
      .payloadT(dcachePkg::lineT),
      .Lanes   (dcachePkg::WordsPerLine)
    ) uDataRam (
      .clk    (clk),
      .en_i   (ramEn),
      .we_i   (wayWe[w]),
      .addr_i (ramIndex),
      .wdata_i(wayWdata),
      .rdata_o(wayRdata[w])
    );
  end

endmodule

/* test/dcache_assertions.sv */
`timescale 1ns/1ps

module dcacheAssertions (
  input logic        clk,
  input logic        rst_n,
  input logic        reqValid_i,
  input logic        reqReady_i,
  input logic        rspValid_i,
  input logic        rspMiss_i,
  input logic        awvalid_i,
  input logic        awready_i,
  input logic [31:0] awaddr_i,
  input logic        wvalid_i,
  input logic        wready_i,
  input logic [31:0] wdata_i,
  input logic [3:0]  wstrb_i,
  input logic        arvalid_i,
  input logic        arready_i,
  input logic [31:0] araddr_i
);

  int failCount = 0;

  awHold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else begin
      failCount++;
      $error("AW dropped or changed before awready");
    end

  wHold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else begin
      failCount++;
      $error("W dropped or changed before wready");
    end

  arHold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
      failCount++;
      $error("AR dropped or changed before arready");
    end

  rspOneCycle: assert property (@(posedge clk) disable iff (!rst_n)
    rspValid_i |=> !rspValid_i)
    else begin
      failCount++;
      $error("response valid longer than one cycle");
    end

  // a hit answers in the cycle right after acceptance
  hitOnlyAfterAccept: assert property (@(posedge clk) disable iff (!rst_n)
    rspValid_i && !rspMiss_i |-> $past(reqValid_i && reqReady_i))
    else begin
      failCount++;
      $error("hit response without acceptance one cycle before");
    end

endmodule

bind dcacheTop dcacheAssertions uAsserts (
  .clk, .rst_n, .reqValid_i, .reqReady_i(reqReady_o), .rspValid_i(rspValid_o),
  .rspMiss_i(rsp_o.miss),
  .awvalid_i(awvalid_o), .awready_i, .awaddr_i(awaddr_o),
  .wvalid_i(wvalid_o), .wready_i, .wdata_i(wdata_o), .wstrb_i(wstrb_o),
  .arvalid_i(arvalid_o), .arready_i, .araddr_i(araddr_o)
);

/* test/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb;

  localparam int MemWords = 1024;
  localparam int StimCols = 6;
  localparam int StimRows = 40;
  localparam int Timeout  = 200;

  logic                clk;
  logic                rst_n;
  logic                reqValid;
  dcachePkg::cpuReqT   req;
  logic                reqReady;
  logic                rspValid;
  dcachePkg::cpuRspT   rsp;
  logic                awvalid, awready, wvalid, wready, bvalid, bready;
  logic                arvalid, arready, rvalid, rready;
  logic [31:0]         awaddr, wdata, araddr, rdata;
  logic [3:0]          wstrb;

  // backing store, and the contents it should hold once stores land
  logic [31:0] mem [MemWords];
  logic [31:0] shadow [MemWords];
  logic [31:0] stimMem [StimCols*StimRows];
  integer      seed;
  int          arCount;

  dcacheTop dut (
    .clk, .rst_n, .reqValid_i(reqValid), .req_i(req), .reqReady_o(reqReady),
    .rspValid_o(rspValid), .rsp_o(rsp),
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr),
    .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
    .bvalid_i(bvalid), .bready_o(bready),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr),
    .rvalid_i(rvalid), .rdata_i(rdata), .rready_o(rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // every address bit shows up in the word
  function automatic logic [31:0] memPattern(input logic [31:0] addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] applyStrobe(
    input logic [31:0] oldWord,
    input logic [31:0] newWord,
    input logic [3:0]  strb
  );
    logic [31:0] res;
    res = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = newWord[8*b +: 8];
    end
    return res;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic checkRange(input logic [31:0] addr);
    if (addr >= 4 * MemWords) begin
      failRun($sformatf("AXI access at %h lies outside the test memory", addr));
    end
  endtask

  // AXI4-Lite slave, sampled at negedge and driven 1 ns after posedge
  initial begin : axiResponder
    logic        awFire, wFire, bFire, arFire, rFire;
    logic        awSeen, wSeen, bPending, rPending;
    logic [31:0] awAddrQ, wDataQ, arAddrQ;
    logic [3:0]  wStrbQ;
    int          bWait, rWait, slot;
    seed = 32'hc395;
    arCount = 0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    awSeen = 1'b0;
    wSeen = 1'b0;
    bPending = 1'b0;
    rPending = 1'b0;
    bWait = 0;
    rWait = 0;
    forever begin
      @(negedge clk);
      awFire = awvalid && awready;
      wFire  = wvalid && wready;
      bFire  = bvalid && bready;
      arFire = arvalid && arready;
      rFire  = rvalid && rready;
      if (awFire) awAddrQ = awaddr;
      if (wFire) begin
        wDataQ = wdata;
        wStrbQ = wstrb;
      end
      if (arFire) begin
        arAddrQ = araddr;
        arCount++;
      end
      @(posedge clk);
      #1;
      if (bFire) bvalid = 1'b0;
      if (rFire) begin
        rvalid = 1'b0;
        rPending = 1'b0;
      end
      if (awFire) awSeen = 1'b1;
      if (wFire) wSeen = 1'b1;
      if (awSeen && wSeen) begin
        checkRange(awAddrQ);
        slot = awAddrQ[11:2];
        // a written-back word must match the latest store seen by the core
        compareValue($sformatf("write-back to %h", awAddrQ), shadow[slot], wDataQ);
        mem[slot] = applyStrobe(mem[slot], wDataQ, wStrbQ);
        awSeen = 1'b0;
        wSeen = 1'b0;
        bPending = 1'b1;
        bWait = $unsigned($random(seed)) % 4;
      end
      if (arFire) begin
        checkRange(arAddrQ);
        rdata = mem[arAddrQ[11:2]];
        rPending = 1'b1;
        rWait = $unsigned($random(seed)) % 4;
      end
      if (bPending && !bvalid) begin
        if (bWait == 0) begin
          bvalid = 1'b1;
          bPending = 1'b0;
        end else begin
          bWait--;
        end
      end
      if (rPending && !rvalid) begin
        if (rWait == 0) rvalid = 1'b1;
        else rWait--;
      end
      awready = ($random(seed) & 3) != 0;
      wready  = ($random(seed) & 3) != 0;
      arready = ($random(seed) & 3) != 0;
    end
  end

  task automatic runAccess(input int num, input logic [31:0] op, input logic [31:0] addr,
                           input logic [31:0] wd, input logic [31:0] strb,
                           input logic [31:0] expData, input logic [31:0] expMiss);
    string name;
    int    arStart;
    int    cycles;
    name = $sformatf("access %0d (%s %h)", num, op[0] ? "store" : "load", addr);
    arStart = arCount;
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    req = '{write: op[0], addr: addr, wdata: wd, strb: strb[3:0]};
    cycles = 0;
    @(negedge clk);
    while (!reqReady) begin
      cycles++;
      if (cycles > Timeout) failRun({"timed out waiting for the cache to take ", name});
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    // cycles counted from the acceptance edge
    cycles = 1;
    @(negedge clk);
    while (!rspValid) begin
      cycles++;
      if (cycles > Timeout) failRun({"timed out waiting for the response to ", name});
      @(negedge clk);
    end
    compareValue({name, " miss flag"}, expMiss, rsp.miss);
    compareValue({name, " data"}, expData, rsp.rdata);
    compareValue({name, " AR count"}, expMiss[0] ? 32'd4 : 32'd0, 32'(arCount - arStart));
    if (!expMiss[0]) compareValue({name, " hit latency"}, 32'd1, 32'(cycles));
    if (op[0]) shadow[addr[11:2]] = applyStrobe(shadow[addr[11:2]], wd, strb[3:0]);
  endtask

  initial begin : mainSeq
    int          row;
    logic [31:0] op;
    rst_n = 1'b0;
    reqValid = 1'b0;
    req = '0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = memPattern(32'(i) << 2);
      shadow[i] = memPattern(32'(i) << 2);
    end
    $readmemh("test/dcache_stim.txt", stimMem);
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    row = 0;
    op = stimMem[0];
    // op f marks the end of the list
    while (op !== 32'hf) begin
      if (row >= StimRows) failRun("stimulus file has no end marker");
      if (op !== 32'h0 && op !== 32'h1) begin
        failRun($sformatf("stimulus row %0d has a bad op code", row));
      end
      runAccess(row, op, stimMem[row*StimCols+1], stimMem[row*StimCols+2],
                stimMem[row*StimCols+3], stimMem[row*StimCols+4], stimMem[row*StimCols+5]);
      row++;
      if (row < StimRows) op = stimMem[row*StimCols];
      else op = 'x;
    end
    if (row == 0) failRun("stimulus file holds no accesses");
    repeat (2) @(posedge clk);
    if (dut.uAsserts.failCount != 0) begin
      $display("%0d assertion failures", dut.uAsserts.failCount);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* test/dcache_stim.txt */
// columns: op (0 load, 1 store, f end) addr wdata strb expected_rdata expected_miss
// memory word at byte address a starts as a ^ 5a5a0000
// cold miss, then hits at every offset
0 00000040 00000000 0 5a5a0040 1
0 00000044 00000000 0 5a5a0044 0
0 00000048 00000000 0 5a5a0048 0
0 0000004c 00000000 0 5a5a004c 0
0 00000040 00000000 0 5a5a0040 0
// partial store hit, store miss with allocate
1 00000044 11223344 3 5a5a3344 0
0 00000044 00000000 0 5a5a3344 0
1 00000088 aabbccdd c aabb0088 1
0 00000088 00000000 0 aabb0088 0
0 0000008c 00000000 0 5a5a008c 0
// three lines in set 2
0 00000020 00000000 0 5a5a0020 1
0 00000124 00000000 0 5a5a0124 1
0 00000028 00000000 0 5a5a0028 0
0 0000022c 00000000 0 5a5a022c 1
0 00000020 00000000 0 5a5a0020 0
0 00000120 00000000 0 5a5a0120 1
// dirty evictions in set 4, stored bytes come back from memory
1 0000014c deadbeef f deadbeef 1
0 00000244 00000000 0 5a5a0244 1
0 00000348 00000000 0 5a5a0348 1
0 00000044 00000000 0 5a5a3344 1
0 0000014c 00000000 0 deadbeef 1
0 00000040 00000000 0 5a5a0040 0
// set 8, dirty victims replaced by stores and loads
1 00000180 12345678 1 5a5a0178 1
1 00000284 9abcdef0 6 5abcde84 1
0 00000088 00000000 0 aabb0088 1
0 00000180 00000000 0 5a5a0178 1
0 00000284 00000000 0 5abcde84 1
0 00000180 00000000 0 5a5a0178 0
0 00000148 00000000 0 5a5a0148 0
0 00000024 00000000 0 5a5a0024 0
f 00000000 00000000 0 00000000 0

/* tb.f */
hdl/dcachePkg.sv
hdl/cacheRam.sv
hdl/dcacheTagStore.sv
hdl/dcacheCtrl.sv
hdl/dcacheTop.sv
test/dcache_assertions.sv
test/dcacheTb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - hdl/dcachePkg.sv
  - hdl/cacheRam.sv
  - hdl/dcacheTagStore.sv
  - hdl/dcacheCtrl.sv
  - hdl/dcacheTop.sv
  - target: test
    files:
      - test/dcache_assertions.sv
      - test/dcacheTb.sv
